//--- design/mem_map_pkg.sv
package mem_map_pkg;

	typedef logic [15:0] word_t;
	typedef logic [15:0] addr_t;

	// Decode result of a word address
	typedef enum logic [2:0] {
		BANK_INST,
		BANK_DATA,
		BANK_UART_DATA,
		BANK_UART_STAT,
		BANK_NONE
	} bank_sel_e;

	// Instruction region also read by fetch
	localparam addr_t INST_BASE  = 16'h0000;
	localparam addr_t INST_LIMIT = 16'h7FFF;

	// Data region
	localparam addr_t DATA_BASE  = 16'h8000;
	localparam addr_t DATA_LIMIT = 16'hBEFF;

	// Serial port registers at the top of the data bank
	localparam addr_t UART_DATA_ADDR = 16'hBF00;
	localparam addr_t UART_STAT_ADDR = 16'hBF01;

	// Anything above UART_STAT_ADDR is unmapped

endpackage

//--- design/mem_bus_pkg.sv
package mem_bus_pkg;

	typedef struct packed {
		logic               psel;
		logic               penable;
		logic               pwrite;
		mem_map_pkg::addr_t paddr;
		mem_map_pkg::word_t pwdata;
	} apb_req_t;

	typedef struct packed {
		logic               pready;
		mem_map_pkg::word_t prdata;
		logic               pslverr;
	} apb_rsp_t;

	// Controller to bank
	typedef struct packed {
		logic                   valid;
		logic                   write;
		mem_map_pkg::bank_sel_e sel;
		mem_map_pkg::addr_t     offset;
		mem_map_pkg::word_t     wdata;
	} bank_req_t;

	typedef struct packed {
		logic               done;
		mem_map_pkg::word_t rdata;
		logic               err;
	} bank_rsp_t;

	typedef struct packed {
		logic               valid;
		mem_map_pkg::addr_t addr;
	} fetch_req_t;

	// addr is the pc the word belongs to
	typedef struct packed {
		logic               valid;
		mem_map_pkg::word_t data;
		mem_map_pkg::addr_t addr;
	} fetch_rsp_t;

	typedef struct packed {
		logic [12:0] zero;
		logic        rx_overflow;
		logic        rx_avail;
		logic        tx_ready;
	} uart_status_t;

endpackage

//--- design/ram_controller.sv
`timescale 1ns/10ps

module ram_controller (
	input  logic                   clk,
	input  logic                   rst,
	input  mem_bus_pkg::apb_req_t  apb_req,
	output mem_bus_pkg::apb_rsp_t  apb_rsp,
	output mem_bus_pkg::bank_req_t inst_req,
	input  mem_bus_pkg::bank_rsp_t inst_rsp,
	output mem_bus_pkg::bank_req_t data_req,
	input  mem_bus_pkg::bank_rsp_t data_rsp
);
	import mem_map_pkg::*;
	import mem_bus_pkg::*;

	typedef enum logic {
		IDLE,
		ACCESS
	} acc_state_e;

	acc_state_e state;
	bank_sel_e  sel;
	addr_t      offset;
	logic       access;
	bank_req_t  bank_req;

	// Address decode
	always_comb begin
		sel = BANK_NONE;
		offset = '0;
		if (apb_req.paddr <= INST_LIMIT) begin
			sel = BANK_INST;
			offset = apb_req.paddr - INST_BASE;
		end else if (apb_req.paddr >= DATA_BASE && apb_req.paddr <= DATA_LIMIT) begin
			sel = BANK_DATA;
			offset = apb_req.paddr - DATA_BASE;
		end else if (apb_req.paddr == UART_DATA_ADDR) begin
			sel = BANK_UART_DATA;
		end else if (apb_req.paddr == UART_STAT_ADDR) begin
			sel = BANK_UART_STAT;
		end
	end

	// Armed by a setup phase and released by the completion
	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else if (apb_req.psel && !apb_req.penable)
			state <= ACCESS;
		else if (apb_rsp.pready)
			state <= IDLE;
	end

	assign access = apb_req.psel && apb_req.penable && state == ACCESS;

	always_comb begin
		bank_req.valid = access;
		bank_req.write = apb_req.pwrite;
		bank_req.sel = sel;
		bank_req.offset = offset;
		bank_req.wdata = apb_req.pwdata;

		inst_req = bank_req;
		inst_req.valid = bank_req.valid && sel == BANK_INST;
		data_req = bank_req;
		data_req.valid = bank_req.valid &&
			sel inside {BANK_DATA, BANK_UART_DATA, BANK_UART_STAT};
	end

	// Response from the selected bank
	always_comb begin
		apb_rsp = '0;
		case (sel)
			BANK_INST: begin
				apb_rsp.pready = inst_rsp.done;
				apb_rsp.prdata = inst_rsp.rdata;
				apb_rsp.pslverr = inst_rsp.err;
			end
			BANK_NONE: begin
				// Unmapped address fails at once
				apb_rsp.pready = access;
				apb_rsp.pslverr = 1'b1;
			end
			default: begin
				apb_rsp.pready = data_rsp.done;
				apb_rsp.prdata = data_rsp.rdata;
				apb_rsp.pslverr = data_rsp.err;
			end
		endcase
	end

	a_paddr_stable: assert property (@(posedge clk) disable iff (rst)
		apb_req.psel && apb_req.penable && !apb_rsp.pready |=> $stable(apb_req.paddr))
		else $error("paddr changed during APB access phase");

endmodule

//--- design/ram2_inst_bank.sv
`timescale 1ns/10ps

module ram2_inst_bank #(
	parameter int INST_DEPTH = 256
) (
	input  logic                    clk,
	input  logic                    rst,
	input  mem_bus_pkg::bank_req_t  exe_req,
	output mem_bus_pkg::bank_rsp_t  exe_rsp,
	input  mem_bus_pkg::fetch_req_t fetch_req,
	output mem_bus_pkg::fetch_rsp_t fetch_rsp
);
	import mem_map_pkg::*;
	import mem_bus_pkg::*;

	localparam int IDX_W = (INST_DEPTH > 1) ? $clog2(INST_DEPTH) : 1;

	typedef enum logic {
		WAIT,
		DONE
	} exe_state_e;

	exe_state_e       state;
	word_t            mem [INST_DEPTH];
	word_t            rd_data;
	logic [IDX_W-1:0] exe_idx;
	logic [IDX_W-1:0] fetch_idx;
	logic [IDX_W-1:0] rd_idx;
	logic             exe_take;
	logic             fetch_take;
	logic             fetch_valid_q;
	addr_t            fetch_addr_q;

	// Power-up contents
	initial begin
		for (int i = 0; i < INST_DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	assign exe_idx = IDX_W'(exe_req.offset % INST_DEPTH);
	assign fetch_idx = IDX_W'(fetch_req.addr % INST_DEPTH);

	// Execute side wins the single port
	assign exe_take = exe_req.valid && exe_req.sel == BANK_INST && state == WAIT;
	assign fetch_take = fetch_req.valid && !exe_take;
	assign rd_idx = exe_take ? exe_idx : fetch_idx;

	always_ff @(posedge clk) begin
		if (exe_take && exe_req.write)
			mem[exe_idx] <= exe_req.wdata;
		rd_data <= mem[rd_idx];
		fetch_addr_q <= fetch_req.addr;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= WAIT;
			fetch_valid_q <= 1'b0;
		end else begin
			fetch_valid_q <= fetch_take;
			case (state)
				WAIT: begin
					if (exe_take)
						state <= DONE;
				end
				DONE: state <= WAIT;
				default: state <= WAIT;
			endcase
		end
	end

	// Both sides read the same output register
	always_comb begin
		exe_rsp.done = state == DONE;
		exe_rsp.rdata = rd_data;
		exe_rsp.err = 1'b0;
		fetch_rsp.valid = fetch_valid_q;
		fetch_rsp.data = rd_data;
		fetch_rsp.addr = fetch_addr_q;
	end

	a_one_completion: assert property (@(posedge clk) disable iff (rst)
		!(exe_rsp.done && fetch_rsp.valid))
		else $error("execute and fetch completed in the same cycle");

endmodule

//--- design/ram1_uart_bank.sv
`timescale 1ns/10ps

module ram1_uart_bank #(
	parameter int DATA_DEPTH = 256,
	parameter int RXQ_DEPTH  = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  mem_bus_pkg::bank_req_t req,
	output mem_bus_pkg::bank_rsp_t rsp,
	input  logic                   rx_valid,
	input  logic [7:0]             rx_byte,
	output logic                   tx_valid,
	output logic [7:0]             tx_byte,
	input  logic                   tx_ready
);
	import mem_map_pkg::*;
	import mem_bus_pkg::*;

	localparam int IDX_W = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;
	localparam int PTR_W = (RXQ_DEPTH > 1) ? $clog2(RXQ_DEPTH) : 1;

	word_t            mem [DATA_DEPTH];
	logic [7:0]       rxq [RXQ_DEPTH];
	logic [PTR_W:0]   rxq_wr_ptr;
	logic [PTR_W:0]   rxq_rd_ptr;
	logic             rxq_empty;
	logic             rxq_full;
	logic             rx_ovf;
	logic             tx_busy;
	logic [7:0]       tx_hold;
	logic [IDX_W-1:0] data_idx;
	logic             data_acc;
	logic             rx_pop;
	logic             stat_rd;
	uart_status_t     status;

	initial begin
		for (int i = 0; i < DATA_DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	assign data_idx = IDX_W'(req.offset % DATA_DEPTH);
	assign data_acc = req.valid && req.sel == BANK_DATA;
	assign stat_rd = req.valid && req.sel == BANK_UART_STAT && !req.write;

	// Extra pointer bit tells a full receive queue from an empty one
	assign rxq_empty = rxq_wr_ptr == rxq_rd_ptr;
	assign rxq_full = rxq_wr_ptr[PTR_W] != rxq_rd_ptr[PTR_W] &&
		rxq_wr_ptr[PTR_W-1:0] == rxq_rd_ptr[PTR_W-1:0];
	assign rx_pop = req.valid && req.sel == BANK_UART_DATA && !req.write && !rxq_empty;

	// Transmit byte is latched while the receiver stalls
	assign tx_valid = req.valid && req.sel == BANK_UART_DATA && req.write;
	assign tx_byte = tx_busy ? tx_hold : req.wdata[7:0];

	always_comb begin
		status = '0;
		status.tx_ready = tx_ready;
		status.rx_avail = !rxq_empty;
		status.rx_overflow = rx_ovf;
	end

	always_comb begin
		rsp = '0;
		if (req.valid) begin
			case (req.sel)
				BANK_DATA: begin
					rsp.done = 1'b1;
					rsp.rdata = mem[data_idx];
				end
				BANK_UART_STAT: begin
					// Read only
					rsp.done = 1'b1;
					rsp.rdata = word_t'(status);
					rsp.err = req.write;
				end
				BANK_UART_DATA: begin
					rsp.done = req.write ? tx_ready : 1'b1;
					rsp.err = !req.write && rxq_empty;
					if (rx_pop)
						rsp.rdata = {8'h00, rxq[rxq_rd_ptr[PTR_W-1:0]]};
				end
				default: rsp = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (data_acc && req.write)
			mem[data_idx] <= req.wdata;
		if (rx_valid && !rxq_full)
			rxq[rxq_wr_ptr[PTR_W-1:0]] <= rx_byte;
		if (tx_valid && !tx_busy)
			tx_hold <= req.wdata[7:0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rxq_wr_ptr <= '0;
			rxq_rd_ptr <= '0;
			rx_ovf <= 1'b0;
			tx_busy <= 1'b0;
		end else begin
			if (rx_valid && !rxq_full)
				rxq_wr_ptr <= rxq_wr_ptr + 1'b1;
			if (rx_pop)
				rxq_rd_ptr <= rxq_rd_ptr + 1'b1;
			// A drop in the same cycle as the status read survives it
			if (stat_rd)
				rx_ovf <= 1'b0;
			if (rx_valid && rxq_full)
				rx_ovf <= 1'b1;
			tx_busy <= tx_valid && !tx_ready;
		end
	end

	a_tx_byte_stable: assert property (@(posedge clk) disable iff (rst)
		tx_valid && !tx_ready |=> $stable(tx_byte))
		else $error("tx_byte changed while waiting for tx_ready");

endmodule

//--- design/mem_subsystem.sv
`timescale 1ns/10ps

module mem_subsystem #(
	parameter int INST_DEPTH = 256,
	parameter int DATA_DEPTH = 256,
	parameter int RXQ_DEPTH  = 4
) (
	input  logic                    clk,
	input  logic                    rst,
	input  mem_bus_pkg::apb_req_t   apb_req,
	output mem_bus_pkg::apb_rsp_t   apb_rsp,
	input  mem_bus_pkg::fetch_req_t fetch_req,
	output mem_bus_pkg::fetch_rsp_t fetch_rsp,
	input  logic                    rx_valid,
	input  logic [7:0]              rx_byte,
	output logic                    tx_valid,
	output logic [7:0]              tx_byte,
	input  logic                    tx_ready
);
	import mem_bus_pkg::*;

	bank_req_t inst_req;
	bank_rsp_t inst_rsp;
	bank_req_t data_req;
	bank_rsp_t data_rsp;

	ram_controller u_ram_controller (
		.clk(clk),
		.rst(rst),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.inst_req(inst_req),
		.inst_rsp(inst_rsp),
		.data_req(data_req),
		.data_rsp(data_rsp)
	);

	// Instruction bank shared with fetch
	ram2_inst_bank #(
		.INST_DEPTH(INST_DEPTH)
	) u_ram2 (
		.clk(clk),
		.rst(rst),
		.exe_req(inst_req),
		.exe_rsp(inst_rsp),
		.fetch_req(fetch_req),
		.fetch_rsp(fetch_rsp)
	);

	ram1_uart_bank #(
		.DATA_DEPTH(DATA_DEPTH),
		.RXQ_DEPTH(RXQ_DEPTH)
	) u_ram1_uart (
		.clk(clk),
		.rst(rst),
		.req(data_req),
		.rsp(data_rsp),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte),
		.tx_valid(tx_valid),
		.tx_byte(tx_byte),
		.tx_ready(tx_ready)
	);

endmodule

//--- testbench/tb_mem_tasks.svh
// One APB transfer that also counts its access cycles
task automatic apb_transfer(input logic write, input addr_t addr, input word_t wdata,
	output word_t rdata, output logic slverr, output int cycles);
	@(posedge clk);
	#1;
	apb_req.psel = 1'b1;
	apb_req.penable = 1'b0;
	apb_req.pwrite = write;
	apb_req.paddr = addr;
	apb_req.pwdata = wdata;
	@(posedge clk);
	#1 apb_req.penable = 1'b1;
	cycles = 0;
	do begin
		@(negedge clk);
		cycles++;
	end while (!apb_rsp.pready);
	rdata = apb_rsp.prdata;
	slverr = apb_rsp.pslverr;
	@(posedge clk);
	#1 apb_req = '0;
endtask

task automatic apb_write_check(input addr_t addr, input word_t data, input logic exp_err,
	input int exp_cycles);
	word_t rdata;
	logic  slverr;
	int    cycles;
	apb_transfer(1'b1, addr, data, rdata, slverr, cycles);
	check_err($sformatf("pslverr write %h", addr), exp_err, slverr);
	check_cycles($sformatf("write %h", addr), exp_cycles, cycles);
endtask

task automatic apb_read_check(input addr_t addr, input word_t exp, input logic exp_err,
	input int exp_cycles);
	word_t rdata;
	logic  slverr;
	int    cycles;
	apb_transfer(1'b0, addr, '0, rdata, slverr, cycles);
	check_word($sformatf("prdata %h", addr), exp, rdata);
	check_err($sformatf("pslverr read %h", addr), exp_err, slverr);
	check_cycles($sformatf("read %h", addr), exp_cycles, cycles);
endtask

function automatic int data_index(input addr_t addr);
	return int'(addr_t'(addr - DATA_BASE)) % DATA_DEPTH;
endfunction

function automatic uart_status_t expected_status(input logic txr, input logic ovf);
	uart_status_t s;
	s = '0;
	s.tx_ready = txr;
	s.rx_avail = rx_model.size() != 0;
	s.rx_overflow = ovf;
	return s;
endfunction

task automatic send_rx(input logic [7:0] b);
	@(posedge clk);
	#1;
	rx_valid = 1'b1;
	rx_byte = b;
	@(posedge clk);
	#1 rx_valid = 1'b0;
	if (rx_model.size() < RXQ_DEPTH)
		rx_model.push_back(b);
	else
		rx_ovf_model = 1'b1;
endtask

task automatic read_status_check();
	word_t rdata;
	logic  slverr;
	int    cycles;
	apb_transfer(1'b0, UART_STAT_ADDR, '0, rdata, slverr, cycles);
	check_status("uart status", expected_status(tx_ready, rx_ovf_model), uart_status_t'(rdata));
	check_cycles("status read", 1, cycles);
	rx_ovf_model = 1'b0;
endtask

task automatic test_data_bank();
	addr_t addrs [6];
	word_t w;
	for (int i = 0; i < 5; i++)
		addrs[i] = addr_t'(DATA_BASE + i * 41);
	addrs[5] = DATA_LIMIT;
	foreach (addrs[i]) begin
		w = word_t'($urandom());
		apb_write_check(addrs[i], w, 1'b0, 1);
		data_model[data_index(addrs[i])] = w;
	end
	foreach (addrs[i])
		apb_read_check(addrs[i], data_model[data_index(addrs[i])], 1'b0, 1);
	// Offset past the depth wraps onto a low index
	w = word_t'($urandom());
	apb_write_check(addr_t'(DATA_BASE + DATA_DEPTH + 5), w, 1'b0, 1);
	data_model[data_index(addr_t'(DATA_BASE + DATA_DEPTH + 5))] = w;
	apb_read_check(addr_t'(DATA_BASE + 5), w, 1'b0, 1);
endtask

task automatic test_inst_bank();
	word_t w;
	for (int i = 0; i < 8; i++) begin
		w = word_t'($urandom());
		apb_write_check(addr_t'(INST_BASE + i), w, 1'b0, 2);
		inst_model[i] = w;
	end
	for (int i = 0; i < 8; i++)
		apb_read_check(addr_t'(INST_BASE + i), inst_model[i], 1'b0, 2);
	@(posedge clk);
	#1;
	fetch_req.valid = 1'b1;
	fetch_req.addr = INST_BASE;
	for (int i = 0; i < 8; i++) begin
		@(posedge clk);
		#1;
		if (i < 7)
			fetch_req.addr = addr_t'(INST_BASE + i + 1);
		else
			fetch_req.valid = 1'b0;
		@(negedge clk);
		check_err("fetch_rsp.valid", 1'b1, fetch_rsp.valid);
		check_word("fetch_rsp.data", inst_model[i], fetch_rsp.data);
		check_word("fetch_rsp.addr", addr_t'(INST_BASE + i), fetch_rsp.addr);
	end
endtask

task automatic test_fetch_conflict();
	@(posedge clk);
	#1;
	apb_req.psel = 1'b1;
	apb_req.pwrite = 1'b0;
	apb_req.paddr = addr_t'(INST_BASE + 3);
	@(posedge clk);
	#1;
	apb_req.penable = 1'b1;
	fetch_req.valid = 1'b1;
	fetch_req.addr = addr_t'(INST_BASE + 5);
	@(negedge clk);
	check_err("apb_rsp.pready", 1'b0, apb_rsp.pready);
	// Fetch held for a retry
	@(posedge clk);
	#1;
	@(negedge clk);
	check_err("fetch_rsp.valid", 1'b0, fetch_rsp.valid);
	check_err("apb_rsp.pready", 1'b1, apb_rsp.pready);
	check_word("apb_rsp.prdata", inst_model[3], apb_rsp.prdata);
	check_err("apb_rsp.pslverr", 1'b0, apb_rsp.pslverr);
	@(posedge clk);
	#1;
	apb_req = '0;
	fetch_req.valid = 1'b0;
	@(negedge clk);
	check_err("fetch_rsp.valid", 1'b1, fetch_rsp.valid);
	check_word("fetch_rsp.data", inst_model[5], fetch_rsp.data);
	check_word("fetch_rsp.addr", addr_t'(INST_BASE + 5), fetch_rsp.addr);
endtask

task automatic test_uart_rx();
	for (int i = 0; i < 3; i++)
		send_rx(8'($urandom()));
	read_status_check();
	while (rx_model.size() != 0)
		apb_read_check(UART_DATA_ADDR, {8'h00, rx_model.pop_front()}, 1'b0, 1);
	// Empty queue
	apb_read_check(UART_DATA_ADDR, '0, 1'b1, 1);
	for (int i = 0; i < RXQ_DEPTH + 1; i++)
		send_rx(8'($urandom()));
	read_status_check();
	read_status_check();
	while (rx_model.size() != 0)
		apb_read_check(UART_DATA_ADDR, {8'h00, rx_model.pop_front()}, 1'b0, 1);
endtask

task automatic test_uart_tx();
	word_t w;
	word_t rdata;
	logic  slverr;
	int    cycles;
	w = word_t'($urandom());
	@(posedge clk);
	#1 tx_ready = 1'b0;
	fork
		apb_transfer(1'b1, UART_DATA_ADDR, w, rdata, slverr, cycles);
		begin
			// tx_valid stays low through the setup phase
			repeat (2) @(negedge clk);
			check_err("tx_valid", 1'b0, tx_valid);
			@(negedge clk);
			for (int k = 0; k < 4; k++) begin
				if (k > 0)
					@(negedge clk);
				check_err("apb_rsp.pready", 1'b0, apb_rsp.pready);
				check_err("tx_valid", 1'b1, tx_valid);
				check_word("tx_byte", {8'h00, w[7:0]}, {8'h00, tx_byte});
			end
			@(posedge clk);
			#1 tx_ready = 1'b1;
			@(negedge clk);
			check_err("apb_rsp.pready", 1'b1, apb_rsp.pready);
			check_err("tx_valid", 1'b1, tx_valid);
			check_word("tx_byte", {8'h00, w[7:0]}, {8'h00, tx_byte});
		end
	join
	check_err("pslverr uart write", 1'b0, slverr);
	check_cycles("uart write", 5, cycles);
endtask

task automatic test_unmapped();
	word_t w;
	apb_read_check(16'hC000, '0, 1'b1, 1);
	apb_write_check(16'hC000, 16'h1234, 1'b1, 1);
	w = word_t'($urandom());
	apb_write_check(16'h8010, w, 1'b0, 1);
	data_model[data_index(16'h8010)] = w;
	apb_read_check(16'h8010, data_model[data_index(16'h8010)], 1'b0, 1);
endtask

//--- testbench/tb_mem_subsystem.sv
`timescale 1ns/10ps

module tb_mem_subsystem;
	import mem_map_pkg::*;
	import mem_bus_pkg::*;

	localparam int INST_DEPTH = 256;
	localparam int DATA_DEPTH = 256;
	localparam int RXQ_DEPTH = 4;
	localparam int NUM_TESTS = 6;
	localparam int TEST_CYCLES_MAX = 500;
	// Test count times the worst case per test with margin
	localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES_MAX + 1000;

	logic       clk;
	logic       rst;
	apb_req_t   apb_req;
	apb_rsp_t   apb_rsp;
	fetch_req_t fetch_req;
	fetch_rsp_t fetch_rsp;
	logic       rx_valid;
	logic [7:0] rx_byte;
	logic       tx_valid;
	logic [7:0] tx_byte;
	logic       tx_ready;

	int errors;
	int checks;

	// Scoreboard
	word_t      data_model [DATA_DEPTH];
	word_t      inst_model [INST_DEPTH];
	logic [7:0] rx_model [$];
	logic       rx_ovf_model;

	mem_subsystem #(
		.INST_DEPTH(INST_DEPTH),
		.DATA_DEPTH(DATA_DEPTH),
		.RXQ_DEPTH(RXQ_DEPTH)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.fetch_req(fetch_req),
		.fetch_rsp(fetch_rsp),
		.rx_valid(rx_valid),
		.rx_byte(rx_byte),
		.tx_valid(tx_valid),
		.tx_byte(tx_byte),
		.tx_ready(tx_ready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	task automatic check_word(input string name, input word_t exp, input word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
		end
	endtask

	task automatic check_err(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH time=%0t %s expected=%b actual=%b", $time, name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input uart_status_t exp,
		input uart_status_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH time=%0t %s expected=%b actual=%b", $time, name, exp, act);
		end
	endtask

	task automatic check_cycles(input string what, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("ERROR time=%0t %s completed after %0d access cycles instead of %0d",
				$time, what, act, exp);
		end
	endtask

	`include "tb_mem_tasks.svh"

	initial begin
		void'($urandom(32'h384d));
		errors = 0;
		checks = 0;
		rst = 1'b1;
		apb_req = '0;
		fetch_req = '0;
		rx_valid = 1'b0;
		rx_byte = 8'h00;
		tx_ready = 1'b1;
		rx_ovf_model = 1'b0;
		for (int i = 0; i < DATA_DEPTH; i++)
			data_model[i] = '0;
		for (int i = 0; i < INST_DEPTH; i++)
			inst_model[i] = '0;
		repeat (10) @(posedge clk);
		#1 rst = 1'b0;

		test_data_bank();
		test_inst_bank();
		test_fetch_conflict();
		test_uart_rx();
		test_uart_tx();
		test_unmapped();

		repeat (2) @(posedge clk);
		$display("checks=%0d errors=%0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- mem_subsystem.f
+incdir+testbench
design/mem_map_pkg.sv
design/mem_bus_pkg.sv
design/ram_controller.sv
design/ram2_inst_bank.sv
design/ram1_uart_bank.sv
design/mem_subsystem.sv
testbench/tb_mem_subsystem.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_mem_subsystem \
		-f mem_subsystem.f -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
